//--- src/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] Word_t;
    typedef logic [63:0] Doubleword_t;
    typedef logic [4:0]  Reg_addr_t;
    typedef logic [31:0] Inst_addr_t;

    // decoded operations handled by execute
    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR,
        OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
        OP_LUI,
        OP_MOVN, OP_MOVZ,
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_JAL, OP_JALR
    } Oper_t;

    typedef struct packed {
        Word_t hi;
        Word_t lo;
    } Hilo_t;

    // instruction as it leaves decode
    typedef struct packed {
        Oper_t      oper;
        Inst_addr_t pc;
        Word_t      reg1;
        Word_t      reg2;
        logic       wreg_write;
        Reg_addr_t  wreg_addr;
    } Issue_t;

    // id/ex payload, valid rides next to the instruction
    typedef struct packed {
        logic   valid;
        Issue_t issue;
    } Idex_t;

    typedef struct packed {
        logic      wreg_write;
        Reg_addr_t wreg_addr;
        Word_t     wreg_data;
        logic      whilo;
        Hilo_t     hilo;
    } Ex_out_t;

    // ex/mem payload
    typedef struct packed {
        logic    valid;
        Ex_out_t res;
    } Exmem_t;

    typedef struct packed {
        logic      wreg_write;
        Reg_addr_t wreg_addr;
        Word_t     wreg_data;
    } Wb_t;

    function automatic logic needs_write_hilo(Oper_t oper);
        return (oper == OP_MULT) || (oper == OP_MULTU) ||
               (oper == OP_MTHI) || (oper == OP_MTLO);
    endfunction

endpackage

//--- src/ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
    input  cpu_pkg::Oper_t      oper_i,
    input  cpu_pkg::Inst_addr_t pc_i,
    input  cpu_pkg::Word_t      reg1_i,
    input  cpu_pkg::Word_t      reg2_i,
    output cpu_pkg::Word_t      data_o,
    output logic                write_o
);

    import cpu_pkg::*;

    Word_t add_res;
    Word_t sub_res;
    Word_t link_addr;
    logic  signed_lt;
    logic  unsigned_lt;
    logic  reg2_zero;

    // no overflow trap, add and addu behave the same
    assign add_res = reg1_i + reg2_i;
    assign sub_res = reg1_i - reg2_i;

    // sign bits decide unless they agree, then the difference does
    assign signed_lt   = (reg1_i[31] != reg2_i[31]) ? reg1_i[31] : sub_res[31];
    assign unsigned_lt = (reg1_i < reg2_i);

    assign reg2_zero = (reg2_i == '0);

    // return address skips the delay slot
    assign link_addr = pc_i + 32'd8;

    always_comb begin
        data_o  = '0;
        write_o = 1'b1;
        case (oper_i)
            OP_AND, OP_ANDI: begin
                data_o = reg1_i & reg2_i;
            end
            OP_OR, OP_ORI: begin
                data_o = reg1_i | reg2_i;
            end
            OP_XOR, OP_XORI: begin
                data_o = reg1_i ^ reg2_i;
            end
            OP_NOR: begin
                data_o = ~(reg1_i | reg2_i);
            end
            // shift amount comes from reg1
            OP_SLL, OP_SLLV: begin
                data_o = reg2_i << reg1_i[4:0];
            end
            OP_SRL, OP_SRLV: begin
                data_o = reg2_i >> reg1_i[4:0];
            end
            OP_SRA, OP_SRAV: begin
                data_o = $signed(reg2_i) >>> reg1_i[4:0];
            end
            OP_LUI: begin
                data_o = {reg2_i[15:0], 16'h0000};
            end
            // conditional moves drop the write when the test fails
            OP_MOVN: begin
                write_o = !reg2_zero;
                data_o  = reg2_zero ? '0 : reg1_i;
            end
            OP_MOVZ: begin
                write_o = reg2_zero;
                data_o  = reg2_zero ? reg1_i : '0;
            end
            OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU: begin
                data_o = add_res;
            end
            OP_SUB, OP_SUBU: begin
                data_o = sub_res;
            end
            OP_SLT, OP_SLTI: begin
                data_o = {31'b0, signed_lt};
            end
            OP_SLTU, OP_SLTIU: begin
                data_o = {31'b0, unsigned_lt};
            end
            OP_JALR: begin
                data_o = link_addr;
            end
            // jal always writes r31
            OP_JAL: begin
                write_o = 1'b1;
                data_o  = link_addr;
            end
            default: begin
                data_o = '0;
            end
        endcase
    end

endmodule

//--- src/ex_mult.sv
`timescale 1ns/1ns

module ex_mult (
    input  logic                 signed_i,
    input  cpu_pkg::Word_t       a_i,
    input  cpu_pkg::Word_t       b_i,
    output cpu_pkg::Doubleword_t product_o
);

    import cpu_pkg::*;

    Word_t       a_mag;
    Word_t       b_mag;
    Doubleword_t mag_product;
    logic        neg_result;

    // unsigned multiply of magnitudes, sign applied afterwards
    assign a_mag = (signed_i && a_i[31]) ? -a_i : a_i;
    assign b_mag = (signed_i && b_i[31]) ? -b_i : b_i;

    assign neg_result = signed_i && (a_i[31] ^ b_i[31]);

    always_comb begin
        mag_product = Doubleword_t'(a_mag) * Doubleword_t'(b_mag);
        if (neg_result) begin
            product_o = -mag_product;
        end else begin
            product_o = mag_product;
        end
    end

endmodule

//--- src/ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
    input  cpu_pkg::Issue_t  ex_i,
    input  cpu_pkg::Ex_out_t mem_i,
    input  cpu_pkg::Ex_out_t wb_i,
    input  cpu_pkg::Hilo_t   hilo_i,
    output cpu_pkg::Ex_out_t result_o
);

    import cpu_pkg::*;

    Word_t       alu_data;
    logic        alu_write;
    Doubleword_t product;
    Hilo_t       hilo_cur;

    ex_alu u_ex_alu (
        .oper_i  (ex_i.oper),
        .pc_i    (ex_i.pc),
        .reg1_i  (ex_i.reg1),
        .reg2_i  (ex_i.reg2),
        .data_o  (alu_data),
        .write_o (alu_write)
    );

    // multu is the only unsigned product
    ex_mult u_ex_mult (
        .signed_i  (ex_i.oper != OP_MULTU),
        .a_i       (ex_i.reg1),
        .b_i       (ex_i.reg2),
        .product_o (product)
    );

    // newest hi/lo wins: mem stage, then wb stage, then the register
    always_comb begin
        if (mem_i.whilo) begin
            hilo_cur = mem_i.hilo;
        end else if (wb_i.whilo) begin
            hilo_cur = wb_i.hilo;
        end else begin
            hilo_cur = hilo_i;
        end
    end

    always_comb begin
        result_o.wreg_addr = ex_i.wreg_addr;
        result_o.wreg_data = alu_data;
        result_o.whilo     = needs_write_hilo(ex_i.oper);
        result_o.hilo      = hilo_cur;

        case (ex_i.oper)
            OP_MOVN, OP_MOVZ, OP_JAL: result_o.wreg_write = alu_write;
            default:                  result_o.wreg_write = ex_i.wreg_write;
        endcase

        case (ex_i.oper)
            OP_MFHI:            result_o.wreg_data = hilo_cur.hi;
            OP_MFLO:            result_o.wreg_data = hilo_cur.lo;
            OP_MUL:             result_o.wreg_data = product[31:0];
            OP_MULT, OP_MULTU:  result_o.hilo = product;
            OP_MTHI:            result_o.hilo.hi = ex_i.reg1;
            OP_MTLO:            result_o.hilo.lo = ex_i.reg1;
            default: begin
            end
        endcase

        // hi/lo writers never touch the register file
        if (result_o.whilo) begin
            result_o.wreg_write = 1'b0;
            result_o.wreg_addr  = '0;
        end
    end

endmodule

//--- src/ex_unit_top.sv
`timescale 1ns/1ns

module ex_unit_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid_i,
    input  cpu_pkg::Issue_t issue_i,
    output cpu_pkg::Wb_t    wb_o,
    output logic            wb_valid_o,
    output cpu_pkg::Hilo_t  hilo_o
);

    import cpu_pkg::*;

    Idex_t   idex_bubble;
    Idex_t   idex_d;
    Idex_t   idex_q;
    Ex_out_t ex_result;
    Exmem_t  exmem_d;
    Exmem_t  exmem_q;
    Ex_out_t memwb_q;
    Hilo_t   hilo_q;

    // empty slot is a nop that writes nothing
    always_comb begin
        idex_bubble = '0;
        idex_bubble.issue.oper = OP_NOP;
    end

    assign idex_d  = issue_valid_i ? Idex_t'{valid: 1'b1, issue: issue_i} : idex_bubble;
    assign exmem_d = '{valid: idex_q.valid, res: ex_result};

    pipe_reg #(.T(Idex_t)) u_idex_reg (
        .clk      (clk),
        .rst      (rst),
        .d_i      (idex_d),
        .bubble_i (idex_bubble),
        .q_o      (idex_q)
    );

    ex_stage u_ex_stage (
        .ex_i     (idex_q.issue),
        .mem_i    (exmem_q.res),
        .wb_i     (memwb_q),
        .hilo_i   (hilo_q),
        .result_o (ex_result)
    );

    pipe_reg #(.T(Exmem_t)) u_exmem_reg (
        .clk      (clk),
        .rst      (rst),
        .d_i      (exmem_d),
        .bubble_i ('0),
        .q_o      (exmem_q)
    );

    // mem stage only passes the result through
    pipe_reg #(.T(Ex_out_t)) u_memwb_reg (
        .clk      (clk),
        .rst      (rst),
        .d_i      (exmem_q.res),
        .bubble_i ('0),
        .q_o      (memwb_q)
    );

    hilo_reg u_hilo_reg (
        .clk    (clk),
        .rst    (rst),
        .we_i   (memwb_q.whilo),
        .hilo_i (memwb_q.hilo),
        .hilo_o (hilo_q)
    );

    assign wb_o.wreg_write = exmem_q.res.wreg_write;
    assign wb_o.wreg_addr  = exmem_q.res.wreg_addr;
    assign wb_o.wreg_data  = exmem_q.res.wreg_data;
    assign wb_valid_o      = exmem_q.valid;
    assign hilo_o          = hilo_q;

endmodule

//--- src/hilo_reg.sv
`timescale 1ns/1ns

module hilo_reg (
    input  logic           clk,
    input  logic           rst,
    input  logic           we_i,
    input  cpu_pkg::Hilo_t hilo_i,
    output cpu_pkg::Hilo_t hilo_o
);

    import cpu_pkg::*;

    Hilo_t hilo_q;

    // architectural copy, written at the end of wb
    always_ff @(posedge clk) begin
        if (rst) begin
            hilo_q <= '0;
        end else if (we_i) begin
            hilo_q <= hilo_i;
        end
    end

    assign hilo_o = hilo_q;

endmodule

//--- src/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     d_i,
    input  T     bubble_i,
    output T     q_o
);

    T q;

    // advances every cycle, reset leaves a bubble behind
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= bubble_i;
        end else begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

//--- verification/ex_unit_tb.sv
`timescale 1ns/1ns

module ex_unit_tb;

    import cpu_pkg::*;

    localparam int CLK_PERIOD = 8;

    typedef struct packed {
        logic       vld;
        logic       lit;
        Oper_t      oper;
        Word_t      reg1;
        Word_t      reg2;
        logic       wr;
        Reg_addr_t  addr;
        Inst_addr_t pc;
        Wb_t        exp_wb;
        Hilo_t      exp_hilo;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        issue_valid;
    Issue_t      issue;
    Wb_t         wb;
    logic        wb_valid;
    Hilo_t       hilo;
    row_t        rows[$];
    int          n = 0;
    logic [15:0] lfsr;

    ex_unit_top u_ex_unit_top (
        .clk           (clk),
        .rst           (rst),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .wb_o          (wb),
        .wb_valid_o    (wb_valid),
        .hilo_o        (hilo)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_wb(input Wb_t got, input Wb_t exp, input string name);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got w=%b a=%0d d=%h exp w=%b a=%0d d=%h", $time, name,
                     got.wreg_write, got.wreg_addr, got.wreg_data,
                     exp.wreg_write, exp.wreg_addr, exp.wreg_data);
            abort_run();
        end
    endtask

    task automatic check_hilo(input Hilo_t got, input Hilo_t exp, input string name);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // galois lfsr stepped once per output bit
    function automatic Word_t lfsr_word();
        Word_t w;
        logic  b;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hB400;
            end
            w = {w[30:0], b};
        end
        return w;
    endfunction

    // reference behavior of one instruction
    // h carries the architectural hi/lo
    task automatic model_instruction(input row_t r, output Wb_t wb_e, inout Hilo_t h);
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        Word_t              d;
        logic               w;
        logic               hw;
        sprod = $signed({{32{r.reg1[31]}}, r.reg1}) * $signed({{32{r.reg2[31]}}, r.reg2});
        uprod = {32'b0, r.reg1} * {32'b0, r.reg2};
        d = '0;
        w = r.wr;
        hw = 1'b0;
        wb_e = '0;
        if (!r.vld) return;
        case (r.oper)
            OP_AND: d = r.reg1 & r.reg2;
            OP_OR: d = r.reg1 | r.reg2;
            OP_XOR: d = r.reg1 ^ r.reg2;
            OP_NOR: d = ~(r.reg1 | r.reg2);
            OP_SLL, OP_SLLV: d = r.reg2 << r.reg1[4:0];
            OP_SRL, OP_SRLV: d = r.reg2 >> r.reg1[4:0];
            OP_SRA, OP_SRAV: d = $signed(r.reg2) >>> r.reg1[4:0];
            OP_LUI: d = {r.reg2[15:0], 16'h0000};
            OP_MOVN, OP_MOVZ: begin
                w = (r.oper == OP_MOVN) ? (r.reg2 != '0) : (r.reg2 == '0);
                d = w ? r.reg1 : '0;
            end
            OP_ADD, OP_ADDU: d = r.reg1 + r.reg2;
            OP_SUB, OP_SUBU: d = r.reg1 - r.reg2;
            OP_SLT: d = {31'b0, $signed(r.reg1) < $signed(r.reg2)};
            OP_SLTU: d = {31'b0, r.reg1 < r.reg2};
            OP_MUL: d = sprod[31:0];
            OP_MFHI: d = h.hi;
            OP_MFLO: d = h.lo;
            OP_JAL, OP_JALR: begin
                w = w | (r.oper == OP_JAL);
                d = r.pc + 32'd8;
            end
            default: d = '0;
        endcase
        case (r.oper)
            OP_MULT: begin
                h = sprod;
                hw = 1'b1;
            end
            OP_MULTU: begin
                h = uprod;
                hw = 1'b1;
            end
            OP_MTHI: begin
                h.hi = r.reg1;
                hw = 1'b1;
            end
            OP_MTLO: begin
                h.lo = r.reg1;
                hw = 1'b1;
            end
            default: hw = 1'b0;
        endcase
        wb_e.wreg_write = hw ? 1'b0 : w;
        wb_e.wreg_addr  = hw ? 5'd0 : r.addr;
        wb_e.wreg_data  = hw ? 32'd0 : d;
    endtask

    task automatic add_row(input logic lit, input Oper_t oper, input Word_t reg1,
                           input Word_t reg2, input logic wr, input Reg_addr_t addr);
        row_t r;
        r = '0;
        r.vld = 1'b1;
        r.lit = lit;
        r.oper = oper;
        r.reg1 = reg1;
        r.reg2 = reg2;
        r.wr = wr;
        r.addr = addr;
        rows.push_back(r);
    endtask

    // zero operands in non-literal rows are drawn from the lfsr
    task automatic build_table();
        row_t  r;
        Hilo_t h;
        add_row(0, OP_AND, 0, 0, 1, 5'd1);
        add_row(0, OP_OR, 0, 0, 1, 5'd2);
        add_row(0, OP_XOR, 0, 0, 1, 5'd3);
        add_row(0, OP_NOR, 0, 0, 1, 5'd4);
        add_row(0, OP_SLLV, 0, 0, 1, 5'd5);
        add_row(0, OP_SRL, 0, 0, 1, 5'd6);
        add_row(1, OP_SRAV, 32'd4, 32'h8000_00F0, 1, 5'd7);
        add_row(0, OP_LUI, 0, 0, 1, 5'd8);
        add_row(0, OP_ADD, 0, 0, 1, 5'd9);
        add_row(0, OP_SUBU, 0, 0, 1, 5'd10);
        add_row(1, OP_SLT, 32'hFFFF_FFFF, 32'd1, 1, 5'd11);
        add_row(1, OP_SLT, 32'd5, 32'hFFFF_FFF0, 1, 5'd12);
        add_row(1, OP_SLTU, 32'hFFFF_FFFF, 32'd1, 1, 5'd13);
        add_row(1, OP_SLTU, 32'd1, 32'h8000_0000, 1, 5'd14);
        add_row(1, OP_MOVN, 32'h1234_5678, 32'd0, 1, 5'd15);
        add_row(1, OP_MOVN, 32'h0000_CAFE, 32'd3, 1, 5'd16);
        add_row(1, OP_MOVZ, 32'h0BAD_F00D, 32'd0, 1, 5'd17);
        add_row(1, OP_MOVZ, 32'h5555_AAAA, 32'd7, 1, 5'd18);
        add_row(1, OP_JAL, 32'd0, 32'd0, 0, 5'd31);
        add_row(0, OP_JALR, 0, 0, 1, 5'd31);
        rows.push_back('0);
        add_row(0, OP_MULT, 0, 0, 0, 5'd0);
        add_row(1, OP_MFHI, 0, 0, 1, 5'd19);
        add_row(1, OP_MFLO, 0, 0, 1, 5'd20);
        add_row(0, OP_MULTU, 0, 0, 0, 5'd0);
        add_row(1, OP_MFLO, 0, 0, 1, 5'd21);
        add_row(0, OP_MUL, 0, 0, 1, 5'd22);
        add_row(0, OP_MTHI, 0, 0, 0, 5'd0);
        add_row(1, OP_MFHI, 0, 0, 1, 5'd23);
        add_row(0, OP_MTLO, 0, 0, 0, 5'd0);
        add_row(0, OP_ADDU, 0, 0, 1, 5'd24);
        add_row(1, OP_MFLO, 0, 0, 1, 5'd25);
        // two hi/lo writers in a row so the mem stage copy must win
        add_row(0, OP_MTHI, 0, 0, 0, 5'd0);
        add_row(0, OP_MTLO, 0, 0, 0, 5'd0);
        add_row(1, OP_MFLO, 0, 0, 1, 5'd26);
        rows.push_back('0);
        rows.push_back('0);
        h = '0;
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            r.pc = 32'h0040_0000 + 4 * i;
            if (r.vld && !r.lit && r.reg1 == '0) r.reg1 = lfsr_word();
            if (r.vld && !r.lit && r.reg2 == '0) r.reg2 = lfsr_word();
            model_instruction(r, r.exp_wb, h);
            r.exp_hilo = h;
            rows[i] = r;
        end
        n = rows.size();
    endtask

    task automatic drive_row(input row_t r);
        issue_valid = r.vld;
        issue.oper = r.oper;
        issue.pc = r.pc;
        issue.reg1 = r.reg1;
        issue.reg2 = r.reg2;
        issue.wreg_write = r.wr;
        issue.wreg_addr = r.addr;
    endtask

    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        lfsr = 16'd48490;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_valid(wb_valid, 1'b0, "wb_valid_o after reset");
        check_wb(wb, '0, "wb_o after reset");
        check_hilo(hilo, '0, "hilo_o after reset");
        // result two edges after issue
        // hi/lo four edges after the drive
        for (int k = 0; k < n + 4; k++) begin
            @(posedge clk);
            #1;
            if (k >= 2 && k - 2 < n) begin
                check_wb(wb, rows[k - 2].exp_wb, $sformatf("wb_o row %0d", k - 2));
                check_valid(wb_valid, rows[k - 2].vld, $sformatf("wb_valid_o row %0d", k - 2));
            end else begin
                check_valid(wb_valid, 1'b0, "wb_valid_o idle");
            end
            if (k >= 4) begin
                check_hilo(hilo, rows[k - 4].exp_hilo, $sformatf("hilo_o row %0d", k - 4));
            end
            if (k < n) begin
                drive_row(rows[k]);
            end else begin
                drive_row('0);
            end
        end
        $display("Testbench passed");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        wait (n > 0);
        #((n + 20) * CLK_PERIOD);
        $display("watchdog expired before all rows were checked");
        abort_run();
    end

endmodule

//--- verilog.f
src/cpu_pkg.sv
src/pipe_reg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_stage.sv
src/hilo_reg.sv
src/ex_unit_top.sv
verification/ex_unit_tb.sv
